// File: Makefile
TOP = tb_flit_merge

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f all.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^=== PASS ===$$'

lint:
	verilator --lint-only --timing -Wall -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: all.f
+incdir+verilog
verilog/tnoc_pkg.sv
verilog/tnoc_flit_if.sv
verilog/tnoc_flit_fifo.sv
verilog/tnoc_round_robin_arbiter.sv
verilog/tnoc_flit_if_arbiter.sv
verilog/tnoc_flit_merge_top.sv
dv/tb_clock_gen.sv
dv/tb_flit_merge.sv

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 4
)(
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 arst_n = 1'b1; // release clear of the edge
  end

endmodule

// File: dv/tb_flit_merge.sv
`timescale 1ns/1ns

`include "tnoc_defs.svh"

module tb_flit_merge;
  import tnoc_pkg::*;

  localparam int WAIT_LIMIT  = 200;
  localparam int DRAIN_LIMIT = 600;

  logic     clk;
  logic     arst_n;
  logic     in_valid [`TNOC_ENTRIES];
  logic     in_ready [`TNOC_ENTRIES];
  tnoc_flit in_flit  [`TNOC_ENTRIES];
  logic     out_valid;
  logic     out_ready;
  tnoc_flit out_flit;

  tnoc_flit    exp_q [`TNOC_ENTRIES][$]; // accepted, not yet seen at the output
  logic [15:0] pkt_seq [`TNOC_ENTRIES];
  string       test_name;
  bit          fair_phase;
  bit          bp_phase;
  bit          hung;
  int          value_errors;
  int          protocol_errors;
  int          timeouts;
  int          fair_checks;

  tb_clock_gen u_clk (
    .clk    (clk),
    .arst_n (arst_n)
  );

  tnoc_flit_merge_top uut (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_flit   (in_flit),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_flit  (out_flit)
  );

//////////////////////////////
// reference and stimulus
//////////////////////////////

  // oldest flit still owed by this source
  function automatic tnoc_flit expected_flit(input int src);
    return exp_q[src].pop_front();
  endfunction

  task automatic wait_accept(input int port, output bit ok);
    int cycles;
    cycles = 0;
    ok     = 1'b0;
    while (!ok && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      ok = in_ready[port];
      cycles++;
    end
  endtask

  task automatic drive_packets(input int port, input int packets);
    int       len;
    bit       ok;
    tnoc_flit flit;
    for (int p = 0; p < packets && !hung; p++) begin
      len = 1 + int'($urandom % 4);
      for (int f = 0; f < len && !hung; f++) begin
        flit.head   = (f == 0);
        flit.tail   = (f == len - 1);
        flit.src_id = tnoc_src_id'(port);
        flit.data   = tnoc_data'({pkt_seq[port], 16'($urandom)});
        in_valid[port] = 1'b1;
        in_flit[port]  = flit;
        wait_accept(port, ok);
        if (ok) begin
          #1;
          exp_q[port].push_back(flit); // visible to the monitor from the next edge
        end else begin
          $display("timeout: input %0d never accepted a flit", port);
          timeouts++;
          hung = 1'b1;
        end
      end
      pkt_seq[port]++;
    end
    in_valid[port] = 1'b0;
  endtask

  task automatic wait_drain();
    int cycles;
    bit empty;
    cycles = 0;
    empty  = 1'b0;
    while (!empty && cycles < DRAIN_LIMIT) begin
      @(negedge clk);
      empty = (exp_q[0].size() == 0) && (exp_q[1].size() == 0) && !out_valid;
      cycles++;
    end
    if (!empty) begin
      $display("timeout: flits still pending at the end of %s", test_name);
      timeouts++;
    end
  endtask

  // random back-pressure, otherwise always ready
  always @(posedge clk) begin
    #1;
    out_ready = bp_phase ? ($urandom % 2 == 1) : 1'b1;
  end

//////////////////////////////
// compare
//////////////////////////////

  always @(posedge clk) begin : compare
    tnoc_flit exp_flit;
    tnoc_flit prev_flit;
    bit       prev_hold;
    bit       in_packet;
    bit       have_last;
    int       open_src;
    int       last_src;
    int       src;
    int       other;
    if (arst_n) begin
      if (prev_hold) begin
        if (!out_valid) begin
          $display("out_valid dropped before its flit was taken (%s)", test_name);
          protocol_errors++;
        end else if (out_flit !== prev_flit) begin
          $display("ERR %s hold: expected %h actual %h", test_name, prev_flit, out_flit);
          value_errors++;
        end
      end
      if (out_valid && out_ready) begin
        src   = int'(out_flit.src_id);
        other = (src + 1) % `TNOC_ENTRIES;
        if (src >= `TNOC_ENTRIES || exp_q[src].size() == 0) begin
          $display("output flit from source %0d that was never sent (%s)", src, test_name);
          protocol_errors++;
        end else begin
          exp_flit = expected_flit(src);
          if (out_flit !== exp_flit) begin
            $display("ERR %s: expected %h actual %h", test_name, exp_flit, out_flit);
            value_errors++;
          end
          if (in_packet && src != open_src) begin
            $display("ERR %s interleave: expected src %0d actual src %0d",
                     test_name, open_src, src);
            value_errors++;
          end
          if (!in_packet && !out_flit.head) begin
            $display("packet started without a header flit (%s)", test_name);
            protocol_errors++;
          end
          // other source had a header waiting, so it must win now
          if (!in_packet && fair_phase && have_last && exp_q[other].size() != 0) begin
            fair_checks++;
            if (src == last_src) begin
              $display("ERR %s: expected src %0d actual src %0d", test_name, other, src);
              value_errors++;
            end
          end
          if (!in_packet) begin
            last_src  = src;
            have_last = 1'b1;
          end
          in_packet = !out_flit.tail;
          open_src  = src;
        end
      end
      prev_hold = out_valid && !out_ready;
      prev_flit = out_flit;
    end
  end

//////////////////////////////
// test sequence
//////////////////////////////

  initial begin : main
    int cycles;
    for (int i = 0; i < `TNOC_ENTRIES; i++) begin
      in_valid[i] = 1'b0;
      in_flit[i]  = '0;
      pkt_seq[i]  = '0;
    end
    out_ready  = 1'b1;
    fair_phase = 1'b0;
    bp_phase   = 1'b0;
    hung       = 1'b0;
    test_name  = "reset";
    void'($urandom(84275));

    cycles = 0;
    while (!arst_n && cycles < 20) begin
      @(negedge clk);
      cycles++;
    end
    if (!arst_n) begin
      $display("timeout: reset never released");
      timeouts++;
    end
    @(posedge clk);
    if (out_valid !== 1'b0) begin
      $display("ERR %s out_valid: expected 0 actual %b", test_name, out_valid);
      value_errors++;
    end
    for (int i = 0; i < `TNOC_ENTRIES; i++) begin
      if (in_ready[i] !== 1'b1) begin
        $display("ERR %s in_ready[%0d]: expected 1 actual %b", test_name, i, in_ready[i]);
        value_errors++;
      end
    end

    test_name = "single_source";
    @(posedge clk);
    #1;
    drive_packets(0, 12);
    wait_drain();

    test_name  = "fairness";
    fair_phase = 1'b1;
    @(posedge clk);
    #1;
    fork
      drive_packets(0, 16);
      drive_packets(1, 16);
    join
    wait_drain();
    fair_phase = 1'b0;
    if (fair_checks == 0) begin
      $display("fairness was never exercised with both sources waiting");
      protocol_errors++;
    end

    test_name = "back_pressure";
    bp_phase  = 1'b1;
    @(posedge clk);
    #1;
    fork
      drive_packets(0, 20);
      drive_packets(1, 20);
    join
    wait_drain();
    bp_phase = 1'b0;

    $display("errors: %0d value, %0d protocol, %0d timeout",
             value_errors, protocol_errors, timeouts);
    if (value_errors + protocol_errors + timeouts == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: verilog/tnoc_defs.svh
`ifndef TNOC_DEFS_SVH
`define TNOC_DEFS_SVH

// flit payload
`define TNOC_DATA_WIDTH 32
`define TNOC_SRC_WIDTH  4

// merge stage shape
`define TNOC_ENTRIES    2
`define TNOC_FIFO_DEPTH 4

`endif

// File: verilog/tnoc_flit_fifo.sv
`timescale 1ns/1ns

`include "tnoc_defs.svh"

module tnoc_flit_fifo #(
  parameter type FLIT_T = tnoc_pkg::tnoc_flit,
  parameter int  DEPTH  = `TNOC_FIFO_DEPTH
)(
  input  logic           clk,
  input  logic           arst_n,
  input  logic           push_valid,
  output logic           push_ready,
  input  FLIT_T          push_data,
  tnoc_flit_if.initiator pop_if
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  FLIT_T            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;

  function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push_ready   = (count != CNT_W'(DEPTH)); // low only when full
  assign push         = push_valid && push_ready;
  assign pop_if.valid = (count != '0);
  assign pop_if.flit  = mem[rd_ptr];              // head entry, no bypass

//////////////////////////////
// storage
//////////////////////////////

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

//////////////////////////////
// pointers and count
//////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop_if.ack) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop_if.ack})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // idle or push and pop together
      endcase
    end
  end

  ap_count_bound: assert property (
    @(posedge clk) disable iff (!arst_n)
    count <= CNT_W'(DEPTH)
  );

  // read side keeps its offer until taken
  ap_pop_hold: assert property (
    @(posedge clk) disable iff (!arst_n)
    (pop_if.valid && !pop_if.ready) |=> (pop_if.valid && $stable(pop_if.flit))
  );

endmodule

// File: verilog/tnoc_flit_if.sv
`timescale 1ns/1ns

`include "tnoc_defs.svh"

interface tnoc_flit_if;
  import tnoc_pkg::*;

  logic     valid;
  logic     ready;
  tnoc_flit flit;
  logic     ack;                // transfer on this edge

  assign ack = valid && ready;

  modport initiator (
    output valid,
    output flit,
    input  ready,
    input  ack
  );

  modport target (
    input  valid,
    input  flit,
    output ready,
    input  ack
  );

endinterface

// File: verilog/tnoc_flit_if_arbiter.sv
`timescale 1ns/1ns

`include "tnoc_defs.svh"

module tnoc_flit_if_arbiter #(
  parameter int ENTRIES = `TNOC_ENTRIES
)(
  input  logic           clk,
  input  logic           arst_n,
  tnoc_flit_if.target    flit_in_if[ENTRIES],
  tnoc_flit_if.initiator flit_out_if
);
  import tnoc_pkg::*;

  logic [ENTRIES-1:0] request;
  logic [ENTRIES-1:0] free;
  logic [ENTRIES-1:0] grant;
  logic [ENTRIES-1:0] in_valid;
  tnoc_flit           in_flit [ENTRIES];
  logic [ENTRIES-1:0] open_grant;   // owner of a packet still in flight

//////////////////////////////
// request and free
//////////////////////////////

  for (genvar i = 0; i < ENTRIES; i++) begin : g_in
    assign request[i] = flit_in_if[i].valid && is_header_flit(flit_in_if[i].flit);
    assign free[i]    = flit_in_if[i].ack && is_tail_flit(flit_in_if[i].flit);
    assign in_valid[i] = flit_in_if[i].valid;
    assign in_flit[i]  = flit_in_if[i].flit;
    assign flit_in_if[i].ready = grant[i] && flit_out_if.ready; // losers see ready low
  end

  tnoc_round_robin_arbiter #(
    .REQUESTS (ENTRIES)
  ) u_arbiter (
    .clk     (clk),
    .arst_n  (arst_n),
    .request (request),
    .free    (free),
    .grant   (grant)
  );

//////////////////////////////
// output mux
//////////////////////////////

  always_comb begin
    flit_out_if.valid = 1'b0;
    flit_out_if.flit  = '0;
    for (int i = 0; i < ENTRIES; i++) begin
      if (grant[i]) begin
        flit_out_if.valid = in_valid[i];
        flit_out_if.flit  = in_flit[i];
      end
    end
  end

  // tracks packets from the output side, independent of the lock
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      open_grant <= '0;
    end else if (flit_out_if.ack) begin
      open_grant <= is_tail_flit(flit_out_if.flit) ? '0 : grant;
    end
  end

  ap_no_switch: assert property (
    @(posedge clk) disable iff (!arst_n)
    (open_grant != '0) |-> (grant == open_grant)
  );

endmodule

// File: verilog/tnoc_flit_merge_top.sv
`timescale 1ns/1ns

`include "tnoc_defs.svh"

module tnoc_flit_merge_top (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               in_valid [`TNOC_ENTRIES],
  output logic               in_ready [`TNOC_ENTRIES],
  input  tnoc_pkg::tnoc_flit in_flit  [`TNOC_ENTRIES],
  output logic               out_valid,
  input  logic               out_ready,
  output tnoc_pkg::tnoc_flit out_flit
);

  tnoc_flit_if fifo_if [`TNOC_ENTRIES] ();  // fifo heads into the arbiter
  tnoc_flit_if out_if ();

//////////////////////////////
// input buffers
//////////////////////////////

  for (genvar i = 0; i < `TNOC_ENTRIES; i++) begin : g_fifo
    tnoc_flit_fifo #(
      .FLIT_T (tnoc_pkg::tnoc_flit),
      .DEPTH  (`TNOC_FIFO_DEPTH)
    ) u_fifo (
      .clk        (clk),
      .arst_n     (arst_n),
      .push_valid (in_valid[i]),
      .push_ready (in_ready[i]),
      .push_data  (in_flit[i]),
      .pop_if     (fifo_if[i])
    );
  end

//////////////////////////////
// packet arbitration
//////////////////////////////

  tnoc_flit_if_arbiter #(
    .ENTRIES (`TNOC_ENTRIES)
  ) u_arbiter (
    .clk         (clk),
    .arst_n      (arst_n),
    .flit_in_if  (fifo_if),
    .flit_out_if (out_if)
  );

  assign out_valid    = out_if.valid;
  assign out_flit     = out_if.flit;
  assign out_if.ready = out_ready;   // back-pressure into the granted fifo

endmodule

// File: verilog/tnoc_pkg.sv
`include "tnoc_defs.svh"

package tnoc_pkg;

  typedef logic [`TNOC_SRC_WIDTH-1:0]  tnoc_src_id;
  typedef logic [`TNOC_DATA_WIDTH-1:0] tnoc_data;

  // single-flit packet carries both head and tail
  typedef struct packed {
    logic       head;
    logic       tail;
    tnoc_src_id src_id;
    tnoc_data   data;
  } tnoc_flit;

  //////////////////////////////
  // flit helpers
  //////////////////////////////

  function automatic logic is_header_flit(tnoc_flit flit);
    return flit.head;
  endfunction

  function automatic logic is_tail_flit(tnoc_flit flit);
    return flit.tail;
  endfunction

endpackage

// File: verilog/tnoc_round_robin_arbiter.sv
`timescale 1ns/1ns

`include "tnoc_defs.svh"

module tnoc_round_robin_arbiter #(
  parameter int REQUESTS = `TNOC_ENTRIES
)(
  input  logic                clk,
  input  logic                arst_n,
  input  logic [REQUESTS-1:0] request,
  input  logic [REQUESTS-1:0] free,
  output logic [REQUESTS-1:0] grant
);

  logic [REQUESTS-1:0] pointer;   // one-hot, highest priority
  logic [REQUESTS-1:0] lock;      // held grant, zero when idle
  logic [REQUESTS-1:0] new_grant;

//////////////////////////////
// priority pick
//////////////////////////////

  // first request at or after the pointer, wrapping around
  always_comb begin : pick
    logic [2*REQUESTS-1:0] double_req;
    logic [2*REQUESTS-1:0] double_grant;
    double_req   = {request, request};
    double_grant = double_req & ~(double_req - {{REQUESTS{1'b0}}, pointer});
    new_grant    = double_grant[REQUESTS-1:0] | double_grant[2*REQUESTS-1:REQUESTS];
  end

  assign grant = (lock != '0) ? lock : new_grant;

//////////////////////////////
// lock and pointer
//////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pointer <= REQUESTS'(1);
      lock    <= '0;
    end else if ((grant & free) != '0) begin
      lock    <= '0;
      pointer <= {grant[REQUESTS-2:0], grant[REQUESTS-1]}; // one past winner
    end else if (lock == '0) begin
      lock    <= new_grant;
    end
  end

  ap_grant_onehot: assert property (
    @(posedge clk) disable iff (!arst_n)
    $onehot0(grant)
  );

endmodule
